// File: include/icache_cfg.svh
// instruction cache geometry
`ifndef ICACHE_CFG_SVH
`define ICACHE_CFG_SVH

// ------------------
// organization
// ------------------

// 8 KB, two ways, 32-byte blocks
`define ICACHE_SETS 128
`define ICACHE_WAYS 2

// 34-bit PA = 22 tag + 7 index + 5 byte offset
`define ICACHE_INDEX_W 7
`define ICACHE_TAG_W 22

// ------------------
// fetch
// ------------------

// two 16-byte slices per block
`define ICACHE_FETCH_BYTES 16
`define ICACHE_FETCH_OFS_W 1

// ------------------
// memory system
// ------------------

// PA without its byte offset
`define BLOCK_ADDR_W 29
`define BLOCK_BITS 256

`endif

// File: logic/system_types_pkg.sv
// memory system types
`include "icache_cfg.svh"

package system_types_pkg;

	// physical block address, as seen by L1 and L2
	typedef logic [`BLOCK_ADDR_W-1:0] block_addr_t;

	// one whole block
	// byte i of the block sits at bits [8i+7:8i]
	typedef logic [`BLOCK_BITS-1:0] block_data_t;

endpackage

// File: logic/icache_pkg.sv
// instruction cache types
`include "icache_cfg.svh"

package icache_pkg;

	typedef logic [`ICACHE_TAG_W-1:0] icache_tag_t;
	typedef logic [`ICACHE_INDEX_W-1:0] icache_index_t;
	typedef logic way_t;

	// one fetch slice, byte 0 in the low bits
	typedef logic [`ICACHE_FETCH_BYTES-1:0][7:0] fetch_slice_t;

	// ------------------
	// block address
	// ------------------

	// raw view goes to and from L2
	// split view is what the arrays index and compare with
	typedef union packed {
		system_types_pkg::block_addr_t raw;
		struct packed {
			icache_tag_t tag;
			icache_index_t index;
		} split;
	} icache_block_addr_u;

endpackage

// File: logic/icache_tag_array.sv
// instruction cache tag array
`timescale 1ns/1ps

`include "icache_cfg.svh"

module icache_tag_array (
	input logic CLK,
	input logic nRST,

	// read port
	input logic rd_valid,
	input icache_pkg::icache_index_t rd_index,

	// fill write
	input logic fill_valid,
	input icache_pkg::way_t fill_way,
	input icache_pkg::icache_block_addr_u fill_addr,

	// snoop invalidation
	input logic inv_valid,
	input icache_pkg::icache_block_addr_u inv_addr,

	// registered read data
	output logic [`ICACHE_WAYS-1:0] rd_valid_by_way,
	output icache_pkg::icache_tag_t [`ICACHE_WAYS-1:0] rd_tag_by_way
);

	import icache_pkg::*;

	logic [`ICACHE_SETS-1:0][`ICACHE_WAYS-1:0] valid_q;
	icache_tag_t tag_q [`ICACHE_SETS][`ICACHE_WAYS];

	// ------------------
	// valid bits
	// ------------------

	// read sees the old state, snoop first so a fill to the same block wins
	always_ff @(posedge CLK or negedge nRST) begin
		if (!nRST) begin
			valid_q <= '0;
			rd_valid_by_way <= '0;
		end else begin
			for (int w = 0; w < `ICACHE_WAYS; w++) begin
				rd_valid_by_way[w] <= rd_valid & valid_q[rd_index][w];
			end
			if (inv_valid) begin
				for (int w = 0; w < `ICACHE_WAYS; w++) begin
					if (tag_q[inv_addr.split.index][w] == inv_addr.split.tag) begin
						valid_q[inv_addr.split.index][w] <= 1'b0;
					end
				end
			end
			if (fill_valid) begin
				valid_q[fill_addr.split.index][fill_way] <= 1'b1;
			end
		end
	end

	// ------------------
	// tags
	// ------------------

	always_ff @(posedge CLK) begin
		for (int w = 0; w < `ICACHE_WAYS; w++) begin
			rd_tag_by_way[w] <= tag_q[rd_index][w];
		end
		if (fill_valid) begin
			tag_q[fill_addr.split.index][fill_way] <= fill_addr.split.tag;
		end
	end

endmodule

// File: logic/icache_data_array.sv
// instruction cache data array
`timescale 1ns/1ps

`include "icache_cfg.svh"

module icache_data_array (
	input logic CLK,

	// read port, one slice per way
	input icache_pkg::icache_index_t rd_index,
	input logic [`ICACHE_FETCH_OFS_W-1:0] rd_ofs,

	// whole-block fill
	input logic fill_valid,
	input icache_pkg::way_t fill_way,
	input icache_pkg::icache_index_t fill_index,
	input system_types_pkg::block_data_t fill_data,

	output icache_pkg::fetch_slice_t [`ICACHE_WAYS-1:0] rd_slice_by_way
);

	import icache_pkg::*;

	// slice 0 is the low half of the block
	fetch_slice_t [(1 << `ICACHE_FETCH_OFS_W)-1:0] data_q [`ICACHE_SETS][`ICACHE_WAYS];

	// read before write
	always_ff @(posedge CLK) begin
		for (int w = 0; w < `ICACHE_WAYS; w++) begin
			rd_slice_by_way[w] <= data_q[rd_index][w][rd_ofs];
		end
		if (fill_valid) begin
			data_q[fill_index][fill_way] <= fill_data;
		end
	end

endmodule

// File: logic/icache_miss_unit.sv
// single outstanding miss handler
`timescale 1ns/1ps

`include "icache_cfg.svh"

module icache_miss_unit (
	input logic CLK,
	input logic nRST,

	// miss feedback from the core
	input logic miss_valid,
	input icache_pkg::icache_tag_t miss_tag,
	input icache_pkg::icache_index_t miss_index,

	// L2 request handshake
	output logic l2_req_valid,
	output system_types_pkg::block_addr_t l2_req_PA29,
	input logic l2_req_ready,

	// L2 response address
	input logic l2_resp_valid,
	input system_types_pkg::block_addr_t l2_resp_PA29,

	// fill command to the arrays
	output logic fill_valid,
	output icache_pkg::icache_block_addr_u fill_addr
);

	import icache_pkg::*;

	typedef enum logic [1:0] {
		S_IDLE,
		S_REQ,
		S_WAIT
	} state_t;

	state_t state_q;
	state_t state_d;
	icache_block_addr_u pend_q;
	logic [1:0] req_age_q;
	logic resp_match;

	// ready comes back through the wrapper registers
	// so it refers to what L2 saw two cycles earlier
	assign resp_match = l2_resp_valid && (l2_resp_PA29 == pend_q.raw);

	always_comb begin
		state_d = state_q;
		fill_valid = 1'b0;
		case (state_q)
			S_IDLE: begin
				if (miss_valid) begin
					state_d = S_REQ;
				end
			end
			S_REQ: begin
				if (req_age_q[1] && l2_req_ready) begin
					state_d = S_WAIT;
				end
			end
			S_WAIT: begin
				// foreign responses are dropped
				if (resp_match) begin
					fill_valid = 1'b1;
					state_d = S_IDLE;
				end
			end
			default: state_d = S_IDLE;
		endcase
	end

	always_ff @(posedge CLK or negedge nRST) begin
		if (!nRST) begin
			state_q <= S_IDLE;
			pend_q <= '0;
			req_age_q <= '0;
		end else begin
			state_q <= state_d;
			req_age_q <= {req_age_q[0], state_q == S_REQ};
			// latch only when idle, a new miss during a pending one is dropped
			if (state_q == S_IDLE && miss_valid) begin
				pend_q.split.tag <= miss_tag;
				pend_q.split.index <= miss_index;
			end
		end
	end

	assign l2_req_valid = (state_q == S_REQ);
	assign l2_req_PA29 = pend_q.raw;
	assign fill_addr = pend_q;

endmodule

// File: logic/icache.sv
// instruction cache core
`timescale 1ns/1ps

`include "icache_cfg.svh"

module icache (
	input logic CLK,
	input logic nRST,

	// req from core
	input logic core_req_valid,
	input logic [`ICACHE_FETCH_OFS_W-1:0] core_req_block_offset,
	input icache_pkg::icache_index_t core_req_index,

	// resp to core
	output logic [`ICACHE_WAYS-1:0] core_resp_valid_by_way,
	output icache_pkg::icache_tag_t [`ICACHE_WAYS-1:0] core_resp_tag_by_way,
	output icache_pkg::fetch_slice_t [`ICACHE_WAYS-1:0] core_resp_instr_16B_by_way,

	// feedback from core
	input logic core_resp_hit_valid,
	input icache_pkg::way_t core_resp_hit_way,
	input logic core_resp_miss_valid,
	input icache_pkg::icache_tag_t core_resp_miss_tag,

	// req to L2
	output logic l2_req_valid,
	output system_types_pkg::block_addr_t l2_req_PA29,
	input logic l2_req_ready,

	// resp from L2
	input logic l2_resp_valid,
	input system_types_pkg::block_addr_t l2_resp_PA29,
	input system_types_pkg::block_data_t l2_resp_data256,

	// L2 snoop inv
	input logic l2_snoop_inv_valid,
	input system_types_pkg::block_addr_t l2_snoop_inv_PA29
);

	import icache_pkg::*;

	icache_index_t resp_index_q;
	logic [`ICACHE_SETS-1:0] lru_q;
	logic fill_valid;
	way_t fill_way;
	icache_block_addr_u fill_addr;
	icache_block_addr_u snoop_addr;

	assign snoop_addr.raw = l2_snoop_inv_PA29;

	// lru bit names the next victim
	assign fill_way = lru_q[fill_addr.split.index];

	// ------------------
	// response index and LRU
	// ------------------

	always_ff @(posedge CLK or negedge nRST) begin
		if (!nRST) begin
			resp_index_q <= '0;
			lru_q <= '0;
		end else begin
			if (core_req_valid) begin
				resp_index_q <= core_req_index;
			end
			if (core_resp_hit_valid) begin
				lru_q[resp_index_q] <= ~core_resp_hit_way;
			end
			// fill after hit, same set goes to the fill
			if (fill_valid) begin
				lru_q[fill_addr.split.index] <= ~fill_way;
			end
		end
	end

	// ------------------
	// arrays and miss unit
	// ------------------

	icache_tag_array tag_array (
		.CLK(CLK),
		.nRST(nRST),
		.rd_valid(core_req_valid),
		.rd_index(core_req_index),
		.fill_valid(fill_valid),
		.fill_way(fill_way),
		.fill_addr(fill_addr),
		.inv_valid(l2_snoop_inv_valid),
		.inv_addr(snoop_addr),
		.rd_valid_by_way(core_resp_valid_by_way),
		.rd_tag_by_way(core_resp_tag_by_way)
	);

	icache_data_array data_array (
		.CLK(CLK),
		.rd_index(core_req_index),
		.rd_ofs(core_req_block_offset),
		.fill_valid(fill_valid),
		.fill_way(fill_way),
		.fill_index(fill_addr.split.index),
		.fill_data(l2_resp_data256),
		.rd_slice_by_way(core_resp_instr_16B_by_way)
	);

	icache_miss_unit miss_unit (
		.CLK(CLK),
		.nRST(nRST),
		.miss_valid(core_resp_miss_valid),
		.miss_tag(core_resp_miss_tag),
		.miss_index(resp_index_q),
		.l2_req_valid(l2_req_valid),
		.l2_req_PA29(l2_req_PA29),
		.l2_req_ready(l2_req_ready),
		.l2_resp_valid(l2_resp_valid),
		.l2_resp_PA29(l2_resp_PA29),
		.fill_valid(fill_valid),
		.fill_addr(fill_addr)
	);

endmodule

// File: logic/icache_wrapper.sv
// registered instruction cache top
`timescale 1ns/1ps

`include "icache_cfg.svh"

module icache_wrapper (
	input logic CLK,
	input logic nRST,

	// req from core
	input logic next_core_req_valid,
	input logic [`ICACHE_FETCH_OFS_W-1:0] next_core_req_block_offset,
	input icache_pkg::icache_index_t next_core_req_index,

	// resp to core
	output logic [`ICACHE_WAYS-1:0] last_core_resp_valid_by_way,
	output icache_pkg::icache_tag_t [`ICACHE_WAYS-1:0] last_core_resp_tag_by_way,
	output icache_pkg::fetch_slice_t [`ICACHE_WAYS-1:0] last_core_resp_instr_16B_by_way,

	// feedback from core
	input logic next_core_resp_hit_valid,
	input icache_pkg::way_t next_core_resp_hit_way,
	input logic next_core_resp_miss_valid,
	input icache_pkg::icache_tag_t next_core_resp_miss_tag,

	// req to L2
	output logic last_l2_req_valid,
	output system_types_pkg::block_addr_t last_l2_req_PA29,
	input logic next_l2_req_ready,

	// resp from L2
	input logic next_l2_resp_valid,
	input system_types_pkg::block_addr_t next_l2_resp_PA29,
	input system_types_pkg::block_data_t next_l2_resp_data256,

	// L2 snoop inv
	input logic next_l2_snoop_inv_valid,
	input system_types_pkg::block_addr_t next_l2_snoop_inv_PA29
);

	import icache_pkg::*;
	import system_types_pkg::*;

	// ------------------
	// core side of the registers
	// ------------------

	logic core_req_valid;
	logic [`ICACHE_FETCH_OFS_W-1:0] core_req_block_offset;
	icache_index_t core_req_index;

	logic [`ICACHE_WAYS-1:0] core_resp_valid_by_way;
	icache_tag_t [`ICACHE_WAYS-1:0] core_resp_tag_by_way;
	fetch_slice_t [`ICACHE_WAYS-1:0] core_resp_instr_16B_by_way;

	logic core_resp_hit_valid;
	way_t core_resp_hit_way;
	logic core_resp_miss_valid;
	icache_tag_t core_resp_miss_tag;

	logic l2_req_valid;
	block_addr_t l2_req_PA29;
	logic l2_req_ready;

	logic l2_resp_valid;
	block_addr_t l2_resp_PA29;
	block_data_t l2_resp_data256;

	logic l2_snoop_inv_valid;
	block_addr_t l2_snoop_inv_PA29;

	icache core (.*);

	// ------------------
	// boundary registers
	// ------------------

	always_ff @(posedge CLK or negedge nRST) begin
		if (!nRST) begin
			core_req_valid <= '0;
			core_req_block_offset <= '0;
			core_req_index <= '0;
			last_core_resp_valid_by_way <= '0;
			last_core_resp_tag_by_way <= '0;
			last_core_resp_instr_16B_by_way <= '0;
			core_resp_hit_valid <= '0;
			core_resp_hit_way <= '0;
			core_resp_miss_valid <= '0;
			core_resp_miss_tag <= '0;
			last_l2_req_valid <= '0;
			last_l2_req_PA29 <= '0;
			l2_req_ready <= '0;
			l2_resp_valid <= '0;
			l2_resp_PA29 <= '0;
			l2_resp_data256 <= '0;
			l2_snoop_inv_valid <= '0;
			l2_snoop_inv_PA29 <= '0;
		end else begin
			// inputs toward the cache core
			core_req_valid <= next_core_req_valid;
			core_req_block_offset <= next_core_req_block_offset;
			core_req_index <= next_core_req_index;
			core_resp_hit_valid <= next_core_resp_hit_valid;
			core_resp_hit_way <= next_core_resp_hit_way;
			core_resp_miss_valid <= next_core_resp_miss_valid;
			core_resp_miss_tag <= next_core_resp_miss_tag;
			l2_req_ready <= next_l2_req_ready;
			l2_resp_valid <= next_l2_resp_valid;
			l2_resp_PA29 <= next_l2_resp_PA29;
			l2_resp_data256 <= next_l2_resp_data256;
			l2_snoop_inv_valid <= next_l2_snoop_inv_valid;
			l2_snoop_inv_PA29 <= next_l2_snoop_inv_PA29;

			// outputs from the cache core
			last_core_resp_valid_by_way <= core_resp_valid_by_way;
			last_core_resp_tag_by_way <= core_resp_tag_by_way;
			last_core_resp_instr_16B_by_way <= core_resp_instr_16B_by_way;
			last_l2_req_valid <= l2_req_valid;
			last_l2_req_PA29 <= l2_req_PA29;
		end
	end

endmodule

// File: sim/icache_l2_model.sv
// L2 cache model
`timescale 1ns/1ps

`include "icache_cfg.svh"

module icache_l2_model (
	input logic CLK,

	// request from the cache
	input logic req_valid,
	input system_types_pkg::block_addr_t req_addr,
	output logic req_ready,

	// fill response
	output logic resp_valid,
	output system_types_pkg::block_addr_t resp_addr,
	output system_types_pkg::block_data_t resp_data,

	// snoop invalidation
	output logic snoop_valid,
	output system_types_pkg::block_addr_t snoop_addr
);

	import system_types_pkg::*;

	// knobs and counters, set and read by the testbench
	logic random_ready;
	logic foreign_en;
	int req_count;
	int addr_changes;
	block_addr_t last_req_addr;

	logic req_seen;
	int wait_cnt;
	block_addr_t resp_q [$];

	// every byte depends on the whole block address
	function automatic logic [7:0] block_byte(input block_addr_t addr, input int pos);
		return addr[7:0] + addr[15:8] * 3 + addr[23:16] * 5 + addr[28:24] * 7 + pos * 29;
	endfunction

	function automatic block_data_t make_block(input block_addr_t addr);
		block_data_t data;
		for (int i = 0; i < `BLOCK_BITS / 8; i++) begin
			data[8*i +: 8] = block_byte(addr, i);
		end
		return data;
	endfunction

	// one-cycle snoop pulse
	task automatic inject_snoop(input block_addr_t addr);
		snoop_valid = 1'b1;
		snoop_addr = addr;
		@(posedge CLK);
		#5;
		snoop_valid = 1'b0;
	endtask

	initial begin
		random_ready = 1'b0;
		foreign_en = 1'b0;
		req_count = 0;
		addr_changes = 0;
		last_req_addr = '0;
		req_seen = 1'b0;
		wait_cnt = 0;
		req_ready = 1'b0;
		resp_valid = 1'b0;
		resp_addr = '0;
		resp_data = '0;
		snoop_valid = 1'b0;
		snoop_addr = '0;
		forever begin
			@(posedge CLK);
			#5;
			resp_valid = 1'b0;
			if (random_ready) begin
				req_ready = ($urandom % 2) == 1;
			end else begin
				req_ready = 1'b1;
			end
			// a rising valid is one request
			if (req_valid && !req_seen) begin
				req_seen = 1'b1;
				req_count++;
				last_req_addr = req_addr;
			end else if (req_valid && req_addr !== last_req_addr) begin
				addr_changes++;
			end
			// valid falls once the cache took ready
			if (!req_valid && req_seen) begin
				req_seen = 1'b0;
				wait_cnt = $urandom_range(4, 1);
				if (foreign_en) begin
					resp_q.push_back(last_req_addr ^
						{{`ICACHE_TAG_W{1'b1}}, {`ICACHE_INDEX_W{1'b0}}});
				end
				resp_q.push_back(last_req_addr);
			end else if (wait_cnt != 0) begin
				wait_cnt--;
			end else if (resp_q.size() != 0) begin
				resp_addr = resp_q.pop_front();
				resp_data = make_block(resp_addr);
				resp_valid = 1'b1;
			end
		end
	end

endmodule

// File: sim/icache_tb.sv
// instruction cache testbench
`timescale 1ns/1ps

`include "icache_cfg.svh"

module icache_tb;

	import icache_pkg::*;
	import system_types_pkg::*;

	localparam int CLK_PERIOD = 100;
	localparam int N_OPS = 40;
	localparam int OP_CYCLES = 60;
	localparam int FILL_TIMEOUT = 40;

	logic CLK;
	logic nRST;

	logic next_core_req_valid;
	logic [`ICACHE_FETCH_OFS_W-1:0] next_core_req_block_offset;
	icache_index_t next_core_req_index;
	logic [`ICACHE_WAYS-1:0] last_core_resp_valid_by_way;
	icache_tag_t [`ICACHE_WAYS-1:0] last_core_resp_tag_by_way;
	fetch_slice_t [`ICACHE_WAYS-1:0] last_core_resp_instr_16B_by_way;
	logic next_core_resp_hit_valid;
	way_t next_core_resp_hit_way;
	logic next_core_resp_miss_valid;
	icache_tag_t next_core_resp_miss_tag;
	logic last_l2_req_valid;
	block_addr_t last_l2_req_PA29;
	logic next_l2_req_ready;
	logic next_l2_resp_valid;
	block_addr_t next_l2_resp_PA29;
	block_data_t next_l2_resp_data256;
	logic next_l2_snoop_inv_valid;
	block_addr_t next_l2_snoop_inv_PA29;

	// mirror of valid bits, tags and LRU
	logic [`ICACHE_WAYS-1:0] m_valid [`ICACHE_SETS];
	icache_tag_t m_tag [`ICACHE_SETS][`ICACHE_WAYS];
	logic m_lru [`ICACHE_SETS];

	// requests in flight, stage 2 is due
	logic pipe_valid [3];
	icache_index_t pipe_index [3];
	logic pipe_ofs [3];

	// one L2 request per miss
	int requests_expected;

	int errors;
	int errors_at_test_start;
	int tests_passed;
	int tests_failed;

	icache_wrapper dut0 (.*);

	icache_l2_model l2_model0 (
		.CLK(CLK),
		.req_valid(last_l2_req_valid),
		.req_addr(last_l2_req_PA29),
		.req_ready(next_l2_req_ready),
		.resp_valid(next_l2_resp_valid),
		.resp_addr(next_l2_resp_PA29),
		.resp_data(next_l2_resp_data256),
		.snoop_valid(next_l2_snoop_inv_valid),
		.snoop_addr(next_l2_snoop_inv_PA29)
	);

	initial begin
		CLK = 1'b0;
		forever #(CLK_PERIOD / 2) CLK = ~CLK;
	end

	initial begin
		repeat (N_OPS * OP_CYCLES) @(posedge CLK);
		$display("watchdog: run did not finish within %0d cycles", N_OPS * OP_CYCLES);
		$display("Simulation failed");
		$finish;
	end

	// ------------------
	// reference and checks
	// ------------------

	function automatic logic [7:0] block_byte(input block_addr_t addr, input int pos);
		return addr[7:0] + addr[15:8] * 3 + addr[23:16] * 5 + addr[28:24] * 7 + pos * 29;
	endfunction

	function automatic fetch_slice_t ref_slice(input block_addr_t addr, input logic ofs);
		fetch_slice_t slice;
		for (int j = 0; j < `ICACHE_FETCH_BYTES; j++) begin
			slice[j] = block_byte(addr, ofs * `ICACHE_FETCH_BYTES + j);
		end
		return slice;
	endfunction

	task automatic check(input string what, input logic [127:0] got, input logic [127:0] exp);
		if (got !== exp) begin
			errors++;
			$display("** Error at %0t: %s: got %h, expected %h", $time, what, got, exp);
		end
	endtask

	task automatic compare_response(input icache_index_t idx, input logic ofs);
		for (int w = 0; w < `ICACHE_WAYS; w++) begin
			check($sformatf("set %0d way %0d valid", idx, w),
				last_core_resp_valid_by_way[w], m_valid[idx][w]);
			if (m_valid[idx][w]) begin
				check($sformatf("set %0d way %0d tag", idx, w),
					last_core_resp_tag_by_way[w], m_tag[idx][w]);
				check($sformatf("set %0d way %0d slice %0d", idx, w, ofs),
					last_core_resp_instr_16B_by_way[w], ref_slice({m_tag[idx][w], idx}, ofs));
			end
		end
	endtask

	// response is out three falling edges after the request was seen
	always @(negedge CLK) begin
		if (!nRST) begin
			for (int i = 0; i < 3; i++) begin
				pipe_valid[i] = 1'b0;
			end
		end else begin
			if (pipe_valid[2]) begin
				compare_response(pipe_index[2], pipe_ofs[2]);
			end
			for (int i = 2; i > 0; i--) begin
				pipe_valid[i] = pipe_valid[i-1];
				pipe_index[i] = pipe_index[i-1];
				pipe_ofs[i] = pipe_ofs[i-1];
			end
			pipe_valid[0] = next_core_req_valid;
			pipe_index[0] = next_core_req_index;
			pipe_ofs[0] = next_core_req_block_offset;
		end
	end

	// ------------------
	// core model
	// ------------------

	task automatic step(input int n);
		repeat (n) begin
			@(posedge CLK);
			#5;
		end
	endtask

	task automatic fetch(input icache_index_t idx, input logic ofs);
		next_core_req_valid = 1'b1;
		next_core_req_index = idx;
		next_core_req_block_offset = ofs;
		step(1);
		next_core_req_valid = 1'b0;
		step(3);
	endtask

	task automatic hit_feedback(input icache_index_t idx, input way_t way);
		next_core_resp_hit_valid = 1'b1;
		next_core_resp_hit_way = way;
		step(1);
		next_core_resp_hit_valid = 1'b0;
		m_lru[idx] = ~way;
		step(1);
	endtask

	task automatic miss_and_fill(input icache_tag_t tag, input icache_index_t idx);
		int n;
		block_addr_t addr;
		way_t victim;
		addr = {tag, idx};
		requests_expected++;
		next_core_resp_miss_valid = 1'b1;
		next_core_resp_miss_tag = tag;
		step(1);
		next_core_resp_miss_valid = 1'b0;
		n = 0;
		do begin
			@(posedge CLK);
			n++;
		end while (!(next_l2_resp_valid && next_l2_resp_PA29 == addr) && n < FILL_TIMEOUT);
		#5;
		if (n >= FILL_TIMEOUT) begin
			errors++;
			$display("fill for block %h did not arrive within %0d cycles", addr, FILL_TIMEOUT);
		end else begin
			victim = m_lru[idx];
			m_valid[idx][victim] = 1'b1;
			m_tag[idx][victim] = tag;
			m_lru[idx] = ~victim;
		end
		check("L2 request count", l2_model0.req_count, requests_expected);
		check("L2 request address", l2_model0.last_req_addr, addr);
		step(1);
	endtask

	// read, then tell the cache whether it hit
	task automatic access(input icache_tag_t tag, input icache_index_t idx, input logic ofs);
		logic hit;
		way_t way;
		fetch(idx, ofs);
		hit = 1'b0;
		way = 1'b0;
		for (int w = 0; w < `ICACHE_WAYS; w++) begin
			if (m_valid[idx][w] && m_tag[idx][w] == tag) begin
				hit = 1'b1;
				way = w;
			end
		end
		if (hit) begin
			hit_feedback(idx, way);
		end else begin
			miss_and_fill(tag, idx);
		end
	endtask

	task automatic snoop_block(input icache_tag_t tag, input icache_index_t idx);
		l2_model0.inject_snoop({tag, idx});
		for (int w = 0; w < `ICACHE_WAYS; w++) begin
			if (m_tag[idx][w] == tag) begin
				m_valid[idx][w] = 1'b0;
			end
		end
		step(1);
	endtask

	task automatic end_test(input string name);
		if (errors == errors_at_test_start) begin
			tests_passed++;
			$display("test %s: passed", name);
		end else begin
			tests_failed++;
			$display("test %s: failed with %0d errors", name, errors - errors_at_test_start);
		end
		errors_at_test_start = errors;
	endtask

	// ------------------
	// tests
	// ------------------

	initial begin
		icache_tag_t ta;
		icache_tag_t tb;
		icache_tag_t tc;
		icache_tag_t rtag [6];
		icache_index_t ridx [6];
		logic rofs [6];
		logic [31:0] rnd;
		rnd = $urandom(32'h34e50249);
		errors = 0;
		errors_at_test_start = 0;
		tests_passed = 0;
		tests_failed = 0;
		requests_expected = 0;
		next_core_req_valid = 1'b0;
		next_core_req_block_offset = '0;
		next_core_req_index = '0;
		next_core_resp_hit_valid = 1'b0;
		next_core_resp_hit_way = 1'b0;
		next_core_resp_miss_valid = 1'b0;
		next_core_resp_miss_tag = '0;
		for (int s = 0; s < `ICACHE_SETS; s++) begin
			m_valid[s] = '0;
			m_lru[s] = 1'b0;
		end
		nRST = 1'b0;
		repeat (2) @(posedge CLK);
		#5;
		nRST = 1'b1;
		step(1);

		fetch(7'd0, 1'b0);
		fetch(7'd0, 1'b1);
		fetch(7'd5, 1'b0);
		fetch(7'd127, 1'b1);
		check("L2 requests after reset", l2_model0.req_count, 0);
		end_test("reset");

		ta = 22'h12345;
		access(ta, 7'd3, 1'b0);
		access(ta, 7'd3, 1'b0);
		access(ta, 7'd3, 1'b1);
		end_test("miss_and_fill");

		// third tag evicts the way not protected by the hit
		ta = 22'h0a0a0;
		tb = 22'h1b1b1;
		tc = 22'h2c2c2;
		access(ta, 7'd9, 1'b0);
		access(tb, 7'd9, 1'b1);
		access(ta, 7'd9, 1'b0);
		access(tc, 7'd9, 1'b0);
		access(ta, 7'd9, 1'b1);
		fetch(7'd3, 1'b1);
		fetch(7'd10, 1'b0);
		end_test("replacement");

		snoop_block(tc, 7'd9);
		fetch(7'd9, 1'b0);
		snoop_block(tb, 7'd9);
		fetch(7'd9, 1'b1);
		snoop_block(22'h12344, 7'd3);
		fetch(7'd3, 1'b0);
		access(ta, 7'd9, 1'b0);
		access(tc, 7'd9, 1'b1);
		end_test("snoop");

		l2_model0.random_ready = 1'b1;
		l2_model0.foreign_en = 1'b1;
		for (int i = 0; i < 6; i++) begin
			rnd = $urandom;
			rtag[i] = rnd[`ICACHE_TAG_W-1:0];
			ridx[i] = rnd[31:31-`ICACHE_INDEX_W+1];
			rofs[i] = rnd[23];
			access(rtag[i], ridx[i], rofs[i]);
		end
		for (int i = 0; i < 6; i++) begin
			access(rtag[i], ridx[i], ~rofs[i]);
		end
		check("L2 address changes under back-pressure", l2_model0.addr_changes, 0);
		check("L2 request count at end", l2_model0.req_count, requests_expected);
		l2_model0.random_ready = 1'b0;
		l2_model0.foreign_en = 1'b0;
		end_test("backpressure");

		step(2);
		$display("tests: %0d passed, %0d failed", tests_passed, tests_failed);
		if (errors == 0) begin
			$display("Simulation passed");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

// File: list.f
+incdir+include
logic/system_types_pkg.sv
logic/icache_pkg.sv
logic/icache_tag_array.sv
logic/icache_data_array.sv
logic/icache_miss_unit.sv
logic/icache.sv
logic/icache_wrapper.sv
sim/icache_l2_model.sv
sim/icache_tb.sv

// File: Bender.yml
package:
  name: icache

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - logic/system_types_pkg.sv
      - logic/icache_pkg.sv
      - logic/icache_tag_array.sv
      - logic/icache_data_array.sv
      - logic/icache_miss_unit.sv
      - logic/icache.sv
      - logic/icache_wrapper.sv
  - target: test
    include_dirs:
      - include
    files:
      - sim/icache_l2_model.sv
      - sim/icache_tb.sv
